// ==== verilog/ddc_pkg.sv ====
package ddc_pkg;

    // Sample format of the complex stream.
    localparam int DATA_W = 16;

    // FIR filter shape.
    localparam int COEF_W  = 18;
    localparam int TAP_NUM = 25;

    localparam string COE_FILE = "fir_coef.mem";  // Hex words, one per tap.

    typedef struct packed {
        logic signed [DATA_W-1:0] i;
        logic signed [DATA_W-1:0] q;
    } iq_t;

    typedef logic signed [COEF_W-1:0] coef_t;

endpackage

// ==== verilog/ddc_cfg_pkg.sv ====
package ddc_cfg_pkg;

    localparam int PHASE_W = 14;
    localparam int LUT_AW  = 8;   // Top phase bits used as table address.
    localparam int DEC_W   = 8;

    localparam real PI = 3.14159265358979;

    typedef struct packed {
        logic               round_type;    // 0 truncates, 1 rounds half up.
        logic [PHASE_W-1:0] phase_inc;
        logic [PHASE_W-1:0] phase_offset;
        logic [DEC_W-1:0]   decimation;    // Zero behaves as one.
    } ddc_cfg_t;

    // Full-scale sine sample for one table slot, nearest integer.
    function automatic logic signed [ddc_pkg::DATA_W-1:0] sin_entry(input int k);
        real angle;
        real amp;
        angle = 2.0 * PI * real'(k) / real'(2 ** LUT_AW);
        amp   = real'(2 ** (ddc_pkg::DATA_W - 1) - 1) * $sin(angle);
        return (ddc_pkg::DATA_W)'(int'(amp));
    endfunction

endpackage

// ==== verilog/nco.sv ====
`timescale 1ns/1ps

module nco (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              en_i,
    input  logic                              step_i,
    input  logic [ddc_cfg_pkg::PHASE_W-1:0]   phase_inc_i,
    input  logic [ddc_cfg_pkg::PHASE_W-1:0]   phase_offset_i,
    output logic signed [ddc_pkg::DATA_W-1:0] cos_o,
    output logic signed [ddc_pkg::DATA_W-1:0] sin_o
);
    import ddc_pkg::*;
    import ddc_cfg_pkg::*;

    logic signed [DATA_W-1:0] sin_rom [2**LUT_AW];
    logic [PHASE_W-1:0]       phase_acc;
    logic [PHASE_W-1:0]       phase_addr;
    logic [LUT_AW-1:0]        sin_addr;
    logic [LUT_AW-1:0]        cos_addr;

    // One full period of sine, constant after elaboration.
    for (genvar k = 0; k < 2**LUT_AW; k++) begin : g_rom
        assign sin_rom[k] = sin_entry(k);
    end

    assign phase_addr = phase_acc + phase_offset_i;
    assign sin_addr   = phase_addr[PHASE_W-1 -: LUT_AW];
    assign cos_addr   = sin_addr + LUT_AW'(2 ** (LUT_AW - 2));  // Quarter period ahead.

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            phase_acc <= '0;
        end else if (en_i && step_i) begin
            phase_acc <= phase_acc + phase_inc_i;
        end
    end

    // Lookup uses the phase before this step's increment.
    always_ff @(posedge clk_i) begin
        if (en_i && step_i) begin
            sin_o <= sin_rom[sin_addr];
            cos_o <= sin_rom[cos_addr];
        end
    end

endmodule

// ==== verilog/mixer.sv ====
`timescale 1ns/1ps

module mixer (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            en_i,
    input  logic                            round_type_i,
    input  logic                            valid_i,
    input  logic [ddc_cfg_pkg::PHASE_W-1:0] phase_inc_i,
    input  logic [ddc_cfg_pkg::PHASE_W-1:0] phase_offset_i,
    input  ddc_pkg::iq_t                    data_i,
    output logic                            valid_o,
    output ddc_pkg::iq_t                    data_o
);
    import ddc_pkg::*;

    logic signed [DATA_W-1:0]   nco_cos;
    logic signed [DATA_W-1:0]   nco_sin;
    logic                       valid_d;
    iq_t                        data_d;
    logic signed [2*DATA_W-1:0] p_ic;
    logic signed [2*DATA_W-1:0] p_qs;
    logic signed [2*DATA_W-1:0] p_qc;
    logic signed [2*DATA_W-1:0] p_is;
    logic signed [2*DATA_W+1:0] rnd;
    logic signed [2*DATA_W+1:0] sum_i;
    logic signed [2*DATA_W+1:0] sum_q;

    function automatic logic signed [DATA_W-1:0] saturate(
        input logic signed [2*DATA_W+1:0] x
    );
        if (x > 2 ** (DATA_W - 1) - 1) begin
            return {1'b0, {(DATA_W-1){1'b1}}};
        end else if (x < -(2 ** (DATA_W - 1))) begin
            return {1'b1, {(DATA_W-1){1'b0}}};
        end
        return x[DATA_W-1:0];
    endfunction

    nco i_nco (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .en_i          (en_i),
        .step_i        (valid_i),
        .phase_inc_i   (phase_inc_i),
        .phase_offset_i(phase_offset_i),
        .cos_o         (nco_cos),
        .sin_o         (nco_sin)
    );

    // (I + jQ) * (cos - j sin).
    assign p_ic = data_d.i * nco_cos;
    assign p_qs = data_d.q * nco_sin;
    assign p_qc = data_d.q * nco_cos;
    assign p_is = data_d.i * nco_sin;

    always_comb begin
        rnd              = '0;
        rnd[DATA_W-2]    = round_type_i;  // Half LSB after the shift.
        sum_i            = p_ic + p_qs + rnd;
        sum_q            = p_qc - p_is + rnd;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_d <= 1'b0;
            valid_o <= 1'b0;
        end else if (en_i) begin
            valid_d <= valid_i;
            valid_o <= valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i && valid_i) begin
            data_d <= data_i;  // Aligns with NCO register.
        end
        if (en_i && valid_d) begin
            data_o.i <= saturate(sum_i >>> (DATA_W - 1));
            data_o.q <= saturate(sum_q >>> (DATA_W - 1));
        end
    end

endmodule

// ==== verilog/fir_decimator.sv ====
`timescale 1ns/1ps

module fir_decimator (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          en_i,
    input  logic                          round_type_i,
    input  logic                          valid_i,
    input  logic [ddc_cfg_pkg::DEC_W-1:0] decimation_i,
    input  ddc_pkg::iq_t                  data_i,
    output logic                          valid_o,
    output ddc_pkg::iq_t                  data_o
);
    import ddc_pkg::*;
    import ddc_cfg_pkg::*;

    coef_t                 coef [TAP_NUM];
    iq_t                   taps [TAP_NUM-1];
    iq_t                   line_next [TAP_NUM];
    logic [DEC_W-1:0]      dec_cnt;
    logic [DEC_W-1:0]      dec_last;
    logic                  group_done;
    logic signed [DATA_W+COEF_W+$clog2(TAP_NUM)-1:0] acc_i;
    logic signed [DATA_W+COEF_W+$clog2(TAP_NUM)-1:0] acc_q;

    function automatic logic signed [DATA_W-1:0] saturate(
        input logic signed [DATA_W+COEF_W+$clog2(TAP_NUM)-1:0] x
    );
        if (x > 2 ** (DATA_W - 1) - 1) begin
            return {1'b0, {(DATA_W-1){1'b1}}};
        end else if (x < -(2 ** (DATA_W - 1))) begin
            return {1'b1, {(DATA_W-1){1'b0}}};
        end
        return x[DATA_W-1:0];
    endfunction

    initial begin
        $readmemh(COE_FILE, coef);
    end

    assign dec_last   = (decimation_i == '0) ? '0 : decimation_i - 1'b1;
    assign group_done = (dec_cnt >= dec_last);

    // 25-sample window: the incoming sample plus the stored history.
    always_comb begin
        line_next[0] = data_i;
        for (int k = 1; k < TAP_NUM; k++) begin
            line_next[k] = taps[k-1];
        end
    end

    always_comb begin
        acc_i             = '0;
        acc_q             = '0;
        acc_i[COEF_W-2]   = round_type_i;  // Half LSB after the shift.
        acc_q[COEF_W-2]   = round_type_i;
        for (int k = 0; k < TAP_NUM; k++) begin
            acc_i += coef[k] * line_next[k].i;
            acc_q += coef[k] * line_next[k].q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dec_cnt <= '0;
            valid_o <= 1'b0;
            for (int k = 0; k < TAP_NUM - 1; k++) begin
                taps[k] <= '0;
            end
        end else if (en_i) begin
            valid_o <= valid_i && group_done;
            if (valid_i) begin
                dec_cnt <= group_done ? '0 : dec_cnt + 1'b1;
                for (int k = 0; k < TAP_NUM - 1; k++) begin
                    taps[k] <= line_next[k];
                end
            end
        end
    end

    // Output only on the last sample of a group.
    always_ff @(posedge clk_i) begin
        if (en_i && valid_i && group_done) begin
            data_o.i <= saturate(acc_i >>> (COEF_W - 1));
            data_o.q <= saturate(acc_q >>> (COEF_W - 1));
        end
    end

endmodule

// ==== verilog/ddc.sv ====
`timescale 1ns/1ps

module ddc (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  en_i,
    input  ddc_cfg_pkg::ddc_cfg_t cfg_i,
    input  logic                  valid_i,
    input  ddc_pkg::iq_t          data_i,
    output logic                  valid_o,
    output ddc_pkg::iq_t          data_o
);
    import ddc_pkg::*;

    logic mix_valid;
    iq_t  mix_data;

    mixer i_mixer (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .en_i          (en_i),
        .round_type_i  (cfg_i.round_type),
        .valid_i       (valid_i),
        .phase_inc_i   (cfg_i.phase_inc),
        .phase_offset_i(cfg_i.phase_offset),
        .data_i        (data_i),
        .valid_o       (mix_valid),
        .data_o        (mix_data)
    );

    fir_decimator i_fir_decimator (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .en_i        (en_i),
        .round_type_i(cfg_i.round_type),
        .valid_i     (mix_valid),
        .decimation_i(cfg_i.decimation),
        .data_i      (mix_data),
        .valid_o     (valid_o),
        .data_o      (data_o)
    );

endmodule

// ==== sim/ddc_checker.sv ====
`timescale 1ns/1ps

module ddc_checker (
    input logic                  clk_i,
    input logic                  rst_i,
    input logic                  en_i,
    input ddc_cfg_pkg::ddc_cfg_t cfg_i,
    input logic                  mix_valid_i,
    input logic                  out_valid_i
);
    import ddc_cfg_pkg::*;

    logic               en_d;
    logic               new_out;
    logic [2*DEC_W-1:0] mix_count;  // Mixer samples since the last output.
    logic [DEC_W-1:0]   min_gap;
    int unsigned        fail_count = 0;

    assign new_out = out_valid_i && en_d;  // A held valid_o is not a new output.
    assign min_gap = (cfg_i.decimation == '0) ? DEC_W'(1) : cfg_i.decimation;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            en_d      <= 1'b0;
            mix_count <= '0;
        end else begin
            en_d <= en_i;
            if (new_out) begin
                mix_count <= {{(2*DEC_W-1){1'b0}}, en_i && mix_valid_i};
            end else if (en_i && mix_valid_i) begin
                mix_count <= mix_count + 1'b1;
            end
        end
    end

    reset_quiet: assert property (@(posedge clk_i) rst_i |=> !out_valid_i)
        else begin
            fail_count++;
            $error("valid_o high after a reset cycle");
        end

    freeze_no_rise: assert property (@(posedge clk_i) !en_i |=> !$rose(out_valid_i))
        else begin
            fail_count++;
            $error("valid_o rose while the chain was frozen");
        end

    group_spacing: assert property (@(posedge clk_i) disable iff (rst_i)
        new_out |-> mix_count >= min_gap)
        else begin
            fail_count++;
            $error("valid_o pulses closer than one decimation group");
        end

endmodule

bind ddc ddc_checker ddc_checker_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .en_i       (en_i),
    .cfg_i      (cfg_i),
    .mix_valid_i(mix_valid),
    .out_valid_i(valid_o)
);

// ==== sim/tb_ddc.sv ====
`timescale 1ns/1ps

module tb_ddc;
    import ddc_pkg::*;
    import ddc_cfg_pkg::*;

    localparam logic [31:0] SEED      = 32'h3911_e735;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1.
    localparam int RST_CYCLES     = 16;
    localparam int IDLE_CYCLES    = 20;
    localparam int NUM_SAMPLES    = 200;
    localparam int SAT_SAMPLES    = 40;
    localparam int MAX_GAP        = 3;
    localparam int DRAIN_CYCLES   = 12;
    localparam int STIM_CYCLES    = 5 * (RST_CYCLES + DRAIN_CYCLES) + IDLE_CYCLES
                                  + NUM_SAMPLES * (3 + MAX_GAP) + 2 * SAT_SAMPLES;
    localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES + 100;
    localparam longint FULL_POS   = 2 ** (DATA_W - 1) - 1;
    localparam longint FULL_NEG   = -(2 ** (DATA_W - 1));

    logic     clk_i = 1'b0;
    logic     rst_i;
    logic     en_i;
    ddc_cfg_t cfg_i;
    logic     valid_i;
    iq_t      data_i;
    logic     valid_o;
    iq_t      data_o;

    coef_t              model_coef [TAP_NUM];
    iq_t                model_hist [TAP_NUM];
    iq_t                expected_q [$];
    logic [PHASE_W-1:0] model_phase;
    int                 model_cnt;
    int                 accepted;
    int                 outputs_seen = 0;
    int                 sat_high;
    int                 sat_low;
    int                 data_errors = 0;
    int                 valid_errors = 0;
    int                 other_errors = 0;
    int                 cycle_count = 0;
    logic [31:0]        lfsr_state;
    logic               en_at_edge = 1'b1;
    logic               rst_at_edge = 1'b1;
    logic               valid_prev = 1'b0;

    ddc ddc_inst (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .en_i   (en_i),
        .cfg_i  (cfg_i),
        .valid_i(valid_i),
        .data_i (data_i),
        .valid_o(valid_o),
        .data_o (data_o)
    );

    always #50 clk_i = ~clk_i;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic iq_t random_iq();
        return iq_t'(take_bits(2 * DATA_W));
    endfunction

    function automatic logic signed [DATA_W-1:0] clip_sample(input longint x);
        if (x > FULL_POS) begin
            return DATA_W'(FULL_POS);
        end else if (x < FULL_NEG) begin
            return DATA_W'(FULL_NEG);
        end
        return x[DATA_W-1:0];
    endfunction

    // Reference chain stepped once per accepted input.
    task automatic model_accept(input iq_t x);
        logic [PHASE_W-1:0] addr;
        logic [LUT_AW-1:0]  idx;
        longint             s;
        longint             c;
        longint             half;
        longint             acc_i;
        longint             acc_q;
        iq_t                mixed;
        iq_t                y;
        int                 dec;
        accepted++;
        addr        = model_phase + cfg_i.phase_offset;
        idx         = addr[PHASE_W-1 -: LUT_AW];
        s           = sin_entry(idx);
        c           = sin_entry((int'(idx) + 2 ** (LUT_AW - 2)) % 2 ** LUT_AW);
        model_phase = model_phase + cfg_i.phase_inc;
        half        = cfg_i.round_type ? (longint'(1) <<< (DATA_W - 2)) : 0;
        mixed.i     = clip_sample((x.i * c + x.q * s + half) >>> (DATA_W - 1));
        mixed.q     = clip_sample((x.q * c - x.i * s + half) >>> (DATA_W - 1));
        for (int k = TAP_NUM - 1; k > 0; k--) begin
            model_hist[k] = model_hist[k-1];
        end
        model_hist[0] = mixed;
        dec = (cfg_i.decimation == 0) ? 1 : int'(cfg_i.decimation);
        model_cnt++;
        if (model_cnt == dec) begin
            model_cnt = 0;
            acc_i = cfg_i.round_type ? (longint'(1) <<< (COEF_W - 2)) : 0;
            acc_q = acc_i;
            for (int k = 0; k < TAP_NUM; k++) begin
                acc_i += longint'(model_coef[k]) * model_hist[k].i;
                acc_q += longint'(model_coef[k]) * model_hist[k].q;
            end
            y.i = clip_sample(acc_i >>> (COEF_W - 1));
            y.q = clip_sample(acc_q >>> (COEF_W - 1));
            expected_q.push_back(y);
        end
    endtask

    task automatic check_iq(input string name, input iq_t exp, input iq_t act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected i=%0d q=%0d, actual i=%0d q=%0d",
                     $time, name, exp.i, exp.q, act.i, act.q);
            data_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %b, actual %b", $time, name, exp, act);
            valid_errors++;
        end
    endtask

    task automatic drive_cycle(input logic en, input logic vld, input iq_t x);
        @(negedge clk_i);
        en_i    = en;
        valid_i = vld;
        data_i  = x;
        if (en && vld) begin
            model_accept(x);
        end
    endtask

    task automatic apply_reset(input ddc_cfg_t cfg);
        rst_i   = 1'b1;
        en_i    = 1'b1;
        valid_i = 1'b0;
        cfg_i   = cfg;
        repeat (RST_CYCLES) @(negedge clk_i);
        rst_i        = 1'b0;
        model_phase  = '0;
        model_cnt    = 0;
        accepted     = 0;
        outputs_seen = 0;
        sat_high     = 0;
        sat_low      = 0;
        for (int k = 0; k < TAP_NUM; k++) begin
            model_hist[k] = '0;
        end
    endtask

    task automatic finish_block(input ddc_cfg_t cfg);
        int dec;
        drive_cycle(1'b1, 1'b0, random_iq());
        while (expected_q.size() != 0) begin
            @(negedge clk_i);
        end
        repeat (DRAIN_CYCLES) @(negedge clk_i);  // Room for any stray pulse.
        dec = (cfg.decimation == 0) ? 1 : int'(cfg.decimation);
        if (outputs_seen != accepted / dec) begin
            $display("Error at %0t: valid_o pulse count expected %0d, actual %0d",
                     $time, accepted / dec, outputs_seen);
            other_errors++;
        end
    endtask

    task automatic run_block(input ddc_cfg_t cfg, input bit gaps);
        int   gap_len;
        logic en_bit;
        logic vld_bit;
        iq_t  x;
        apply_reset(cfg);
        for (int n = 0; n < NUM_SAMPLES; n++) begin
            gap_len = gaps ? int'(take_bits(2)) : 0;
            for (int g = 0; g < gap_len; g++) begin
                en_bit  = (take_bits(1) == 0);  // Idle cycle or frozen cycle.
                vld_bit = en_bit ? 1'b0 : (take_bits(1) != 0);
                x       = random_iq();
                drive_cycle(en_bit, vld_bit, x);
            end
            x = random_iq();
            drive_cycle(1'b1, 1'b1, x);
        end
        finish_block(cfg);
    endtask

    task automatic print_error_counts();
        $display("Errors: data %0d, valid %0d, other %0d, assertion %0d",
                 data_errors, valid_errors, other_errors,
                 ddc_inst.ddc_checker_inst.fail_count);
    endtask

    always @(posedge clk_i) begin
        en_at_edge  <= en_i;
        rst_at_edge <= rst_i;
    end

    always @(negedge clk_i) begin
        if (rst_at_edge) begin
            check_bit("valid_o", 1'b0, valid_o);
        end else if (!en_at_edge) begin
            check_bit("valid_o", valid_prev, valid_o);  // Frozen chain holds.
        end else if (valid_o) begin
            outputs_seen++;
            if (expected_q.size() == 0) begin
                $display("Unexpected output on valid_o at %0t", $time);
                other_errors++;
            end else begin
                check_iq("data_o", expected_q.pop_front(), data_o);
            end
            if (data_o.i == FULL_POS) begin
                sat_high++;
            end
            if (data_o.i == FULL_NEG) begin
                sat_low++;
            end
        end
        valid_prev = valid_o;
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            other_errors++;
            print_error_counts();
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        ddc_cfg_t cfg;
        iq_t      x;
        lfsr_state = SEED;
        rst_i      = 1'b1;
        en_i       = 1'b1;
        valid_i    = 1'b0;
        data_i     = '0;
        cfg_i      = '0;
        $readmemh("verilog/fir_coef.mem", model_coef);
        if ($isunknown(model_coef[TAP_NUM/2])) begin
            $display("Could not read the FIR coefficient file");
            other_errors++;
        end

        cfg = '0;
        apply_reset(cfg);
        for (int n = 0; n < IDLE_CYCLES; n++) begin
            drive_cycle(1'b1, 1'b0, random_iq());
            check_bit("valid_o", 1'b0, valid_o);
        end

        cfg.round_type   = 1'b0;
        cfg.phase_inc    = PHASE_W'(take_bits(PHASE_W));
        cfg.phase_offset = PHASE_W'(take_bits(PHASE_W));
        cfg.decimation   = DEC_W'(1);
        run_block(cfg, 1'b0);

        cfg.round_type   = 1'b1;
        cfg.phase_inc    = PHASE_W'(take_bits(PHASE_W));
        cfg.phase_offset = PHASE_W'(take_bits(PHASE_W));
        cfg.decimation   = DEC_W'(2 + take_bits(3) % 7);
        run_block(cfg, 1'b0);

        cfg.round_type   = (take_bits(1) != 0);
        cfg.phase_inc    = PHASE_W'(take_bits(PHASE_W));
        cfg.phase_offset = PHASE_W'(take_bits(PHASE_W));
        cfg.decimation   = DEC_W'(take_bits(3));  // Zero acts as one.
        run_block(cfg, 1'b1);

        cfg.round_type   = 1'b0;
        cfg.phase_inc    = '0;
        cfg.phase_offset = PHASE_W'(2 ** (PHASE_W - 3));  // Eighth period where cos equals sin.
        cfg.decimation   = DEC_W'(1);
        apply_reset(cfg);
        for (int n = 0; n < 2 * SAT_SAMPLES; n++) begin
            x.i = (n < SAT_SAMPLES) ? DATA_W'(FULL_POS) : DATA_W'(FULL_NEG);
            x.q = x.i;
            drive_cycle(1'b1, 1'b1, x);
        end
        finish_block(cfg);
        if (sat_high == 0 || sat_low == 0) begin
            $display("Full-scale block never drove data_o into saturation");
            other_errors++;
        end

        print_error_counts();
        if (data_errors + valid_errors + other_errors == 0 &&
            ddc_inst.ddc_checker_inst.fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== verilog/fir_coef.mem ====
// One 18-bit two's complement FIR coefficient per line, tap 0 first.
3FF6A
3FECA
3FE5C
3FEA2
00000
0044C
00B54
01518
0206C
02C24
0364C
03D54
04204
03D54
0364C
02C24
0206C
01518
00B54
0044C
00000
3FEA2
3FE5C
3FECA
3FF6A

// ==== src.f ====
verilog/ddc_pkg.sv
verilog/ddc_cfg_pkg.sv
verilog/nco.sv
verilog/mixer.sv
verilog/fir_decimator.sv
verilog/ddc.sv
sim/ddc_checker.sv
sim/tb_ddc.sv
